/* build.f */
+incdir+sim
verilog/rv32i_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/mem_align.sv
verilog/rv32i_pipeline.sv
sim/tb_rv32i_pipeline.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_rv32i_pipeline -o tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* sim/tb_ref_model.svh */
rv32i_isa_pkg::word_t prog[$];
rv32i_isa_pkg::word_t exp_addr[$];
rv32i_isa_pkg::word_t exp_data[$];
logic [3:0]           exp_mbe[$];
int                   store_slot;

function automatic rv32i_isa_pkg::word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                               int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'(rv32i_isa_pkg::op_reg)};
endfunction

function automatic rv32i_isa_pkg::word_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                               logic [6:0] opc);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic rv32i_isa_pkg::word_t enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'(rv32i_isa_pkg::op_store)};
endfunction

function automatic rv32i_isa_pkg::word_t enc_u(logic [19:0] imm, int rd);
    return {imm, 5'(rd), 7'(rv32i_isa_pkg::op_lui)};
endfunction

// mixes every address bit so that aliasing shows up
function automatic rv32i_isa_pkg::word_t dmem_init(int i);
    return (rv32i_isa_pkg::word_t'(i) * 32'h9e37_79b9) ^ 32'h80ff_7f01;
endfunction

// word store of a register into the next free result slot
function automatic void add_sw(int rs2);
    prog.push_back(enc_s(12'(128 + 4 * store_slot), rs2, 0, 3'b010));
    store_slot++;
endfunction

function automatic void build_program();
    store_slot = 0;
    prog.push_back(enc_i(12'd100, 0, 3'b000, 1, 7'(rv32i_isa_pkg::op_imm)));
    prog.push_back(enc_i(-12'sd7, 0, 3'b000, 2, 7'(rv32i_isa_pkg::op_imm)));
    prog.push_back(enc_r(7'h00, 2, 1, 3'b000, 3));
    prog.push_back(enc_r(7'h20, 1, 3, 3'b000, 4));
    prog.push_back(enc_i(12'd2, 0, 3'b000, 6, 7'(rv32i_isa_pkg::op_imm)));
    prog.push_back(enc_r(7'h20, 6, 2, 3'b101, 5));
    prog.push_back(enc_r(7'h00, 1, 2, 3'b010, 7));
    prog.push_back(enc_r(7'h00, 1, 2, 3'b011, 8));
    prog.push_back(enc_u(20'h80000, 9));
    prog.push_back(enc_i(12'h404, 9, 3'b101, 10, 7'(rv32i_isa_pkg::op_imm)));
    prog.push_back(enc_i(12'h5a5, 10, 3'b100, 11, 7'(rv32i_isa_pkg::op_imm)));
    prog.push_back(enc_r(7'h00, 6, 11, 3'b001, 15));
    prog.push_back(enc_r(7'h00, 4, 15, 3'b110, 16));
    prog.push_back(enc_r(7'h00, 5, 16, 3'b111, 17));
    prog.push_back(enc_i(-12'sd1, 17, 3'b011, 18, 7'(rv32i_isa_pkg::op_imm)));
    for (int r = 3; r <= 18; r++) begin
        if (r != 6 && r != 12 && r != 13 && r != 14) begin
            add_sw(r);
        end
    end
    // load-use pair
    prog.push_back(enc_i(12'd8, 0, 3'b010, 12, 7'(rv32i_isa_pkg::op_load)));
    prog.push_back(enc_r(7'h00, 1, 12, 3'b000, 13));
    add_sw(13);
    // byte and halfword lanes
    for (int off = 0; off < 4; off++) begin
        prog.push_back(enc_s(12'(224 + off), 11, 0, 3'b000));
    end
    for (int off = 0; off < 4; off += 2) begin
        prog.push_back(enc_s(12'(232 + off), 17, 0, 3'b001));
    end
    // load extension at each legal offset
    for (int off = 0; off < 4; off++) begin
        prog.push_back(enc_i(12'(16 + off), 0, 3'b000, 14, 7'(rv32i_isa_pkg::op_load)));
        add_sw(14);
        prog.push_back(enc_i(12'(20 + off), 0, 3'b100, 14, 7'(rv32i_isa_pkg::op_load)));
        add_sw(14);
    end
    for (int off = 0; off < 4; off += 2) begin
        prog.push_back(enc_i(12'(24 + off), 0, 3'b001, 14, 7'(rv32i_isa_pkg::op_load)));
        add_sw(14);
        prog.push_back(enc_i(12'(28 + off), 0, 3'b101, 14, 7'(rv32i_isa_pkg::op_load)));
        add_sw(14);
    end
endfunction

function automatic rv32i_isa_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                                 rv32i_isa_pkg::word_t a, rv32i_isa_pkg::word_t b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: return (a < b) ? 32'd1 : 32'd0;
        3'b100: return a ^ b;
        3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// ISA-level run of the program, fills the expected store stream
function automatic void run_reference();
    rv32i_isa_pkg::word_t regs [32];
    rv32i_isa_pkg::word_t mem [64];
    rv32i_isa_pkg::word_t ins, res, addr, imm_i, imm_s, lane;
    logic [3:0]           be;
    int                   rd;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) mem[i] = dmem_init(i);
    foreach (prog[n]) begin
        ins   = prog[n];
        rd    = int'(ins[11:7]);
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        res   = '0;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'h000};
            7'b0010011: res = ref_alu(ins[14:12], ins[14:12] == 3'b101 && ins[30],
                                      regs[ins[19:15]], imm_i);
            7'b0110011: res = ref_alu(ins[14:12], ins[30], regs[ins[19:15]], regs[ins[24:20]]);
            7'b0000011: begin
                addr = regs[ins[19:15]] + imm_i;
                lane = mem[addr[7:2]] >> (8 * addr[1:0]);
                case (ins[14:12])
                    3'b000: res = {{24{lane[7]}}, lane[7:0]};
                    3'b100: res = {24'd0, lane[7:0]};
                    3'b001: res = {{16{lane[15]}}, lane[15:0]};
                    3'b101: res = {16'd0, lane[15:0]};
                    default: res = lane;
                endcase
            end
            7'b0100011: begin
                addr = regs[ins[19:15]] + imm_s;
                be   = (ins[14:12] == 3'b000) ? 4'b0001 << addr[1:0] :
                       (ins[14:12] == 3'b001) ? 4'b0011 << addr[1:0] : 4'b1111;
                res  = regs[ins[24:20]] << (8 * addr[1:0]);
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) mem[addr[7:2]][8*b +: 8] = res[8*b +: 8];
                end
                exp_addr.push_back({addr[31:2], 2'b00});
                exp_data.push_back(res);
                exp_mbe.push_back(be);
                rd = 0;
            end
            default: rd = 0;
        endcase
        if (rd != 0) regs[rd] = res;
    end
endfunction

/* sim/tb_rv32i_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_pipeline;

    localparam rv32i_isa_pkg::word_t reset_pc = 32'h0000_1000;
    localparam int wait_limit = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_read, inst_resp;
    rv32i_isa_pkg::word_t inst_addr, inst_rdata;
    logic                 data_read, data_write, data_resp;
    logic [3:0]           data_mbe;
    rv32i_isa_pkg::word_t data_addr, data_wdata, data_rdata;

    rv32i_isa_pkg::word_t dmem [64];
    rv32i_isa_pkg::word_t obs_addr[$];
    rv32i_isa_pkg::word_t obs_data[$];
    logic [3:0]           obs_mbe[$];

    `include "tb_ref_model.svh"

    rv32i_pipeline #(.reset_pc(reset_pc)) dut (
        .clk_i(clk), .rst_n_i(rst_n),
        .inst_read_o(inst_read), .inst_addr_o(inst_addr),
        .inst_resp_i(inst_resp), .inst_rdata_i(inst_rdata),
        .data_read_o(data_read), .data_write_o(data_write), .data_mbe_o(data_mbe),
        .data_addr_o(data_addr), .data_wdata_o(data_wdata),
        .data_resp_i(data_resp), .data_rdata_i(data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(string name, rv32i_isa_pkg::word_t got, rv32i_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // instruction memory, answers after 0 to 3 idle cycles
    initial begin
        int idx;
        int delay;
        delay = 0;
        forever begin
            @(posedge clk);
            #1;
            inst_resp = 1'b0;
            if (!rst_n || !inst_read) begin
                delay = $urandom % 4;
            end else if (delay == 0) begin
                idx        = (inst_addr - reset_pc) >> 2;
                inst_rdata = (idx < prog.size()) ? prog[idx] : rv32i_isa_pkg::nop_instr;
                inst_resp  = 1'b1;
                delay      = $urandom % 4;
            end else begin
                delay--;
            end
        end
    end

    // data memory, stores are logged in the cycle they are answered
    initial begin
        int delay;
        delay = 0;
        forever begin
            @(posedge clk);
            #1;
            data_resp = 1'b0;
            if (!rst_n || !(data_read || data_write)) begin
                delay = $urandom % 4;
            end else if (delay == 0) begin
                if (data_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_mbe[b]) dmem[data_addr[7:2]][8*b +: 8] = data_wdata[8*b +: 8];
                    end
                    obs_addr.push_back(data_addr);
                    obs_data.push_back(data_wdata);
                    obs_mbe.push_back(data_mbe);
                end else begin
                    data_rdata = dmem[data_addr[7:2]];
                end
                data_resp = 1'b1;
                delay     = $urandom % 4;
            end else begin
                delay--;
            end
        end
    end

    initial begin
        int                   cycles;
        rv32i_isa_pkg::word_t mask;
        rst_n      = 1'b0;
        inst_resp  = 1'b0;
        inst_rdata = '0;
        data_resp  = 1'b0;
        data_rdata = '0;
        void'($urandom(32'h8265));
        for (int i = 0; i < 64; i++) dmem[i] = dmem_init(i);
        build_program();
        run_reference();

        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            #1;
            check_value("inst_read_o", 32'(inst_read), 32'd0);
            check_value("data_read_o", 32'(data_read), 32'd0);
            check_value("data_write_o", 32'(data_write), 32'd0);
        end
        rst_n = 1'b1;

        cycles = 0;
        while (!inst_read) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > wait_limit) fail_timeout("the first fetch");
        end
        check_value("inst_addr_o", inst_addr, reset_pc);

        // compare each store with the head of the expected stream
        while (exp_addr.size() > 0) begin
            cycles = 0;
            while (obs_addr.size() == 0) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > wait_limit) fail_timeout("a store on the data bus");
            end
            for (int b = 0; b < 4; b++) begin
                mask[8*b +: 8] = {8{exp_mbe[0][b]}};
            end
            check_value("data_addr_o", obs_addr.pop_front(), exp_addr.pop_front());
            check_value("data_mbe_o", 32'(obs_mbe.pop_front()), 32'(exp_mbe[0]));
            check_value("data_wdata_o", obs_data.pop_front() & mask, exp_data.pop_front() & mask);
            void'(exp_mbe.pop_front());
        end

        // nothing but nops follows, so no further store may appear
        repeat (40) @(posedge clk);
        #1;
        check_value("extra stores", 32'(obs_addr.size()), 32'd0);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rv32i_isa_pkg::alu_op_e op_i,
    input  wire                    alt_i,
    input  rv32i_isa_pkg::word_t   a_i,
    input  rv32i_isa_pkg::word_t   b_i,
    output rv32i_isa_pkg::word_t   result_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv32i_isa_pkg::alu_add:  result_o = alt_i ? a_i - b_i : a_i + b_i;
            rv32i_isa_pkg::alu_sll:  result_o = a_i << shamt;
            rv32i_isa_pkg::alu_slt:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            rv32i_isa_pkg::alu_sltu: result_o = {31'd0, a_i < b_i};
            rv32i_isa_pkg::alu_xor:  result_o = a_i ^ b_i;
            rv32i_isa_pkg::alu_sr: begin
                // arithmetic when alt is set
                if (alt_i) begin
                    result_o = $unsigned($signed(a_i) >>> shamt);
                end else begin
                    result_o = a_i >> shamt;
                end
            end
            rv32i_isa_pkg::alu_or:   result_o = a_i | b_i;
            rv32i_isa_pkg::alu_and:  result_o = a_i & b_i;
            default:                 result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  rv32i_isa_pkg::reg_addr_t ex_rs1_i,
    input  rv32i_isa_pkg::reg_addr_t ex_rs2_i,
    input  rv32i_isa_pkg::reg_addr_t mem_rd_i,
    input  rv32i_isa_pkg::reg_addr_t wb_rd_i,
    input  rv32i_isa_pkg::reg_addr_t id_rs1_i,
    input  rv32i_isa_pkg::reg_addr_t id_rs2_i,
    input  rv32i_isa_pkg::reg_addr_t ex_rd_i,
    input  wire                      mem_reg_write_i,
    input  wire                      wb_reg_write_i,
    input  wire                      ex_mem_read_i,
    input  wire                      inst_read_i,
    input  wire                      inst_resp_i,
    input  wire                      data_access_i,
    input  wire                      data_resp_i,
    output pipe_ctrl_pkg::fwd_sel_e  fwd_a_o,
    output pipe_ctrl_pkg::fwd_sel_e  fwd_b_o,
    output logic                     load_use_o,
    output logic                     stall_o
);

    // younger result (memory stage) wins over writeback
    function automatic pipe_ctrl_pkg::fwd_sel_e pick_fwd(rv32i_isa_pkg::reg_addr_t rs);
        pipe_ctrl_pkg::fwd_sel_e sel;
        sel = pipe_ctrl_pkg::fwd_rf;
        if (rs != '0) begin
            if (mem_reg_write_i && mem_rd_i == rs) begin
                sel = pipe_ctrl_pkg::fwd_mem;
            end else if (wb_reg_write_i && wb_rd_i == rs) begin
                sel = pipe_ctrl_pkg::fwd_wb;
            end
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_fwd(ex_rs1_i);
    assign fwd_b_o = pick_fwd(ex_rs2_i);

    // load data is only ready in writeback, one cycle too late for execute
    assign load_use_o = ex_mem_read_i && (ex_rd_i != '0)
                        && (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

    // either bus still waiting
    assign stall_o = (inst_read_i && !inst_resp_i) || (data_access_i && !data_resp_i);

endmodule

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  rv32i_isa_pkg::word_t       instr_i,
    output pipe_ctrl_pkg::stage_info_t info_o,
    output pipe_ctrl_pkg::ctrl_word_t  ctrl_o
);

    logic [2:0]           funct3;
    rv32i_isa_pkg::word_t imm_i;
    rv32i_isa_pkg::word_t imm_s;
    rv32i_isa_pkg::word_t imm_u;

    assign funct3 = instr_i[14:12];
    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u  = {instr_i[31:12], 12'h000};

    always_comb begin
        info_o.rd  = instr_i[11:7];
        info_o.rs1 = instr_i[19:15];
        info_o.rs2 = instr_i[24:20];
        info_o.imm = imm_i;
        ctrl_o     = pipe_ctrl_pkg::ctrl_bubble;

        case (rv32i_isa_pkg::opcode_e'(instr_i[6:0]))
            rv32i_isa_pkg::op_lui: begin
                // x0 + u-immediate
                info_o.rs1       = '0;
                info_o.rs2       = '0;
                info_o.imm       = imm_u;
                ctrl_o.alu_b_sel = pipe_ctrl_pkg::alu_b_imm;
                ctrl_o.reg_write = 1'b1;
            end
            rv32i_isa_pkg::op_imm: begin
                info_o.rs2       = '0;
                ctrl_o.alu_op    = rv32i_isa_pkg::alu_op_e'(funct3);
                // bit 30 is only an opcode bit for srai, elsewhere it is immediate
                ctrl_o.alt       = (funct3 == rv32i_isa_pkg::f3_sr) && instr_i[30];
                ctrl_o.alu_b_sel = pipe_ctrl_pkg::alu_b_imm;
                ctrl_o.reg_write = 1'b1;
            end
            rv32i_isa_pkg::op_reg: begin
                ctrl_o.alu_op    = rv32i_isa_pkg::alu_op_e'(funct3);
                ctrl_o.alt       = instr_i[30];
                ctrl_o.reg_write = 1'b1;
            end
            rv32i_isa_pkg::op_load: begin
                info_o.rs2       = '0;
                ctrl_o.alu_b_sel = pipe_ctrl_pkg::alu_b_imm;
                ctrl_o.wb_sel    = pipe_ctrl_pkg::wb_load;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.mem_read  = 1'b1;
                ctrl_o.mem_size  = funct3;
            end
            rv32i_isa_pkg::op_store: begin
                info_o.rd        = '0;
                info_o.imm       = imm_s;
                ctrl_o.alu_b_sel = pipe_ctrl_pkg::alu_b_imm;
                ctrl_o.mem_write = 1'b1;
                ctrl_o.mem_size  = funct3;
            end
            default: begin
                // unknown opcode runs as a bubble
                info_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mem_align.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_align (
    input  wire [2:0]            size_i,
    input  wire [1:0]            byte_off_i,
    input  rv32i_isa_pkg::word_t store_data_i,
    output rv32i_isa_pkg::word_t wdata_o,
    output logic [3:0]           mbe_o,
    input  rv32i_isa_pkg::word_t load_word_i,
    output rv32i_isa_pkg::word_t load_data_o
);

    logic [4:0]           bit_off;
    rv32i_isa_pkg::word_t lane;

    // byte offset times eight
    assign bit_off = {byte_off_i, 3'b000};

    // store side
    assign wdata_o = store_data_i << bit_off;

    always_comb begin
        case (rv32i_isa_pkg::store_f3_e'(size_i))
            rv32i_isa_pkg::f3_sb: mbe_o = 4'b0001 << byte_off_i;
            rv32i_isa_pkg::f3_sh: mbe_o = 4'b0011 << byte_off_i;
            default:              mbe_o = 4'b1111;
        endcase
    end

    // load side, addressed lane moved down to bit 0 first
    assign lane = load_word_i >> bit_off;

    always_comb begin
        case (rv32i_isa_pkg::load_f3_e'(size_i))
            rv32i_isa_pkg::f3_lb:  load_data_o = {{24{lane[7]}}, lane[7:0]};
            rv32i_isa_pkg::f3_lbu: load_data_o = {24'd0, lane[7:0]};
            rv32i_isa_pkg::f3_lh:  load_data_o = {{16{lane[15]}}, lane[15:0]};
            rv32i_isa_pkg::f3_lhu: load_data_o = {16'd0, lane[15:0]};
            default:               load_data_o = load_word_i;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/pipe_ctrl_pkg.sv */
`default_nettype none

package pipe_ctrl_pkg;

    typedef enum logic {
        alu_b_rs2 = 1'b0,
        alu_b_imm = 1'b1
    } alu_b_sel_e;

    typedef enum logic {
        wb_alu  = 1'b0,
        wb_load = 1'b1
    } wb_sel_e;

    typedef enum logic [1:0] {
        fwd_rf  = 2'b00,
        fwd_mem = 2'b01,
        fwd_wb  = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        rv32i_isa_pkg::alu_op_e alu_op;
        // sub / sra select, taken from funct7 bit 5
        logic                   alt;
        alu_b_sel_e             alu_b_sel;
        wb_sel_e                wb_sel;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        // funct3 of the load or store
        logic [2:0]             mem_size;
    } ctrl_word_t;

    typedef struct packed {
        rv32i_isa_pkg::reg_addr_t rd;
        rv32i_isa_pkg::reg_addr_t rs1;
        rv32i_isa_pkg::reg_addr_t rs2;
        rv32i_isa_pkg::word_t     imm;
    } stage_info_t;

    // no register write, no memory access
    localparam ctrl_word_t ctrl_bubble = '{
        alu_op:    rv32i_isa_pkg::alu_add,
        alt:       1'b0,
        alu_b_sel: alu_b_rs2,
        wb_sel:    wb_alu,
        reg_write: 1'b0,
        mem_read:  1'b0,
        mem_write: 1'b0,
        mem_size:  3'b000
    };

endpackage

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       we_i,
    input  rv32i_isa_pkg::reg_addr_t  waddr_i,
    input  rv32i_isa_pkg::reg_addr_t  raddr_a_i,
    input  rv32i_isa_pkg::reg_addr_t  raddr_b_i,
    input  rv32i_isa_pkg::word_t      wdata_i,
    output rv32i_isa_pkg::word_t      rdata_a_o,
    output rv32i_isa_pkg::word_t      rdata_b_o
);

    rv32i_isa_pkg::word_t regs [32];
    logic                 wr_en;

    // x0 never written
    assign wr_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-before-read, so decode sees the value retiring this cycle
    assign rdata_a_o = (wr_en && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (wr_en && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

/* verilog/rv32i_isa_pkg.sv */
`default_nettype none

package rv32i_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_f3_e;

    typedef enum logic [2:0] {
        f3_lb  = 3'b000,
        f3_lh  = 3'b001,
        f3_lw  = 3'b010,
        f3_lbu = 3'b100,
        f3_lhu = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        f3_sb = 3'b000,
        f3_sh = 3'b001,
        f3_sw = 3'b010
    } store_f3_e;

    // same encoding as the arithmetic funct3, so decode is a straight cast
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_e;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

/* verilog/rv32i_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module rv32i_pipeline #(
    parameter rv32i_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    output logic                  inst_read_o,
    output rv32i_isa_pkg::word_t  inst_addr_o,
    input  wire                   inst_resp_i,
    input  rv32i_isa_pkg::word_t  inst_rdata_i,
    output logic                  data_read_o,
    output logic                  data_write_o,
    output logic [3:0]            data_mbe_o,
    output rv32i_isa_pkg::word_t  data_addr_o,
    output rv32i_isa_pkg::word_t  data_wdata_o,
    input  wire                   data_resp_i,
    input  rv32i_isa_pkg::word_t  data_rdata_i
);

    rv32i_isa_pkg::word_t       pc;
    rv32i_isa_pkg::word_t       if_id_instr;
    pipe_ctrl_pkg::stage_info_t id_info;
    pipe_ctrl_pkg::ctrl_word_t  id_ctrl;
    rv32i_isa_pkg::word_t       rf_rs1;
    rv32i_isa_pkg::word_t       rf_rs2;

    pipe_ctrl_pkg::ctrl_word_t  id_ex_ctrl, ex_mem_ctrl, mem_wb_ctrl;
    pipe_ctrl_pkg::stage_info_t id_ex_info, ex_mem_info, mem_wb_info;
    rv32i_isa_pkg::word_t       id_ex_rs1, id_ex_rs2;
    rv32i_isa_pkg::word_t       ex_mem_alu, ex_mem_store;
    rv32i_isa_pkg::word_t       mem_wb_alu, mem_wb_load;

    pipe_ctrl_pkg::fwd_sel_e    fwd_a, fwd_b;
    rv32i_isa_pkg::word_t       rs1_fwd, rs2_fwd, alu_b, alu_result;
    rv32i_isa_pkg::word_t       mem_load_data, wb_value;
    logic                       stall, load_use;
    logic                       data_done;
    rv32i_isa_pkg::word_t       data_hold, load_word;

    // fetch
    assign inst_addr_o = pc;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inst_read_o <= 1'b0;
            pc          <= reset_pc;
            if_id_instr <= rv32i_isa_pkg::nop_instr;
        end else begin
            inst_read_o <= 1'b1;
            if (inst_read_o && !stall && !load_use) begin
                pc          <= pc + 32'd4;
                if_id_instr <= inst_rdata_i;
            end
        end
    end

    // decode
    instr_decoder u_decoder (.instr_i(if_id_instr), .info_o(id_info), .ctrl_o(id_ctrl));

    regfile u_regfile (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .we_i(mem_wb_ctrl.reg_write), .waddr_i(mem_wb_info.rd), .wdata_i(wb_value),
        .raddr_a_i(id_info.rs1), .raddr_b_i(id_info.rs2),
        .rdata_a_o(rf_rs1), .rdata_b_o(rf_rs2)
    );

    hazard_unit u_hazard (
        .ex_rs1_i(id_ex_info.rs1), .ex_rs2_i(id_ex_info.rs2),
        .mem_rd_i(ex_mem_info.rd), .wb_rd_i(mem_wb_info.rd),
        .id_rs1_i(id_info.rs1), .id_rs2_i(id_info.rs2), .ex_rd_i(id_ex_info.rd),
        .mem_reg_write_i(ex_mem_ctrl.reg_write), .wb_reg_write_i(mem_wb_ctrl.reg_write),
        .ex_mem_read_i(id_ex_ctrl.mem_read),
        .inst_read_i(inst_read_o), .inst_resp_i(inst_resp_i),
        .data_access_i(data_read_o | data_write_o), .data_resp_i(data_resp_i),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .load_use_o(load_use), .stall_o(stall)
    );

    // execute operand muxes
    always_comb begin
        case (fwd_a)
            pipe_ctrl_pkg::fwd_mem: rs1_fwd = ex_mem_alu;
            pipe_ctrl_pkg::fwd_wb:  rs1_fwd = wb_value;
            default:                rs1_fwd = id_ex_rs1;
        endcase
        case (fwd_b)
            pipe_ctrl_pkg::fwd_mem: rs2_fwd = ex_mem_alu;
            pipe_ctrl_pkg::fwd_wb:  rs2_fwd = wb_value;
            default:                rs2_fwd = id_ex_rs2;
        endcase
    end

    assign alu_b = (id_ex_ctrl.alu_b_sel == pipe_ctrl_pkg::alu_b_imm) ? id_ex_info.imm : rs2_fwd;

    alu u_alu (
        .op_i(id_ex_ctrl.alu_op), .alt_i(id_ex_ctrl.alt),
        .a_i(rs1_fwd), .b_i(alu_b), .result_o(alu_result)
    );

    // memory
    // answer that arrives while fetch still waits is held until the pipe moves
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !stall) begin
            data_done <= 1'b0;
        end else if (data_resp_i) begin
            data_done <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_resp_i) begin
            data_hold <= data_rdata_i;
        end
    end

    assign data_read_o  = ex_mem_ctrl.mem_read && !data_done;
    assign data_write_o = ex_mem_ctrl.mem_write && !data_done;
    assign data_addr_o  = {ex_mem_alu[31:2], 2'b00};
    assign load_word    = data_done ? data_hold : data_rdata_i;

    mem_align u_align (
        .size_i(ex_mem_ctrl.mem_size), .byte_off_i(ex_mem_alu[1:0]),
        .store_data_i(ex_mem_store), .wdata_o(data_wdata_o), .mbe_o(data_mbe_o),
        .load_word_i(load_word), .load_data_o(mem_load_data)
    );

    // writeback
    assign wb_value = (mem_wb_ctrl.wb_sel == pipe_ctrl_pkg::wb_load) ? mem_wb_load : mem_wb_alu;

    // stage control, a load-use hazard drops a bubble into execute
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_ex_ctrl  <= pipe_ctrl_pkg::ctrl_bubble;
            ex_mem_ctrl <= pipe_ctrl_pkg::ctrl_bubble;
            mem_wb_ctrl <= pipe_ctrl_pkg::ctrl_bubble;
        end else if (!stall) begin
            id_ex_ctrl  <= load_use ? pipe_ctrl_pkg::ctrl_bubble : id_ctrl;
            ex_mem_ctrl <= id_ex_ctrl;
            mem_wb_ctrl <= ex_mem_ctrl;
        end
    end

    // stage payload
    always_ff @(posedge clk_i) begin
        if (!stall) begin
            id_ex_info   <= id_info;
            id_ex_rs1    <= rf_rs1;
            id_ex_rs2    <= rf_rs2;
            ex_mem_info  <= id_ex_info;
            ex_mem_alu   <= alu_result;
            ex_mem_store <= rs2_fwd;
            mem_wb_info  <= ex_mem_info;
            mem_wb_alu   <= ex_mem_alu;
            mem_wb_load  <= mem_load_data;
        end
    end

endmodule

`default_nettype wire
